// File: rtl/soc_pkg.sv
package soc_pkg;

   // native bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W/8;

   // data bus: set selects the peripheral bus, clear the internal memory
   localparam int P_BIT = 14;
   // inside internal memory: set selects the boot control register
   localparam int B_BIT = 13;

   // sram word address width
   localparam int SRAM_ADDR_W = 10;
   // word address bit forced high on fetches while booting
   localparam int BOOT_OFFSET_BIT = 9;
   // cpu reset pulse length in clock edges
   localparam int CPU_RESET_CYCLES = 4;

   localparam int GPIO_W = 16;

   // request side, a write when any strobe is set
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } bus_req_t;

   // response side, ready lasts one cycle
   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              ready;
   } bus_resp_t;

endpackage

// File: rtl/bus_split.sv
`timescale 1ns/10ps

module bus_split import soc_pkg::*; #(
   parameter int N_SLAVES = 2,
   parameter int P_SLAVES = P_BIT
) (
   input  logic                       clk,
   input  logic                       arst_n,
   // master side
   input  bus_req_t                   m_req,
   output bus_resp_t                  m_resp,
   // slave side, slave 0 in the low bits
   output bus_req_t  [N_SLAVES-1:0]   s_req,
   input  bus_resp_t [N_SLAVES-1:0]   s_resp
);

   localparam int SEL_W = (N_SLAVES > 1) ? $clog2(N_SLAVES) : 1;

   logic [SEL_W-1:0] sel;
   logic [SEL_W-1:0] sel_q;
   logic             pending;

   // slave index sits in the address bits ending at P_SLAVES
   assign sel = m_req.addr[P_SLAVES -: SEL_W];

   // all fields go everywhere, only valid is steered
   always_comb begin
      for (int i = 0; i < N_SLAVES; i++) begin
         s_req[i]       = m_req;
         s_req[i].valid = m_req.valid && (sel == SEL_W'(i));
      end
   end

   // remember who was addressed until the answer comes back
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sel_q <= '0;
      end else if (m_req.valid) begin
         sel_q <= sel;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pending <= 1'b0;
      end else if (m_req.valid) begin
         pending <= 1'b1;
      end else if (m_resp.ready) begin
         pending <= 1'b0;
      end
   end

   assign m_resp = s_resp[sel_q];

   // a master may only reissue once the response is on the bus
   property p_no_valid_while_pending;
      @(posedge clk) disable iff (!arst_n)
         m_req.valid |-> (!pending || m_resp.ready);
   endproperty

   a_no_valid_while_pending: assert property (p_no_valid_while_pending)
      else $error("bus_split: request issued while a response is pending");

endmodule

// File: rtl/dp_sram.sv
`timescale 1ns/10ps

module dp_sram import soc_pkg::*; (
   input  logic                   clk,
   // instruction port, read only
   input  logic                   i_en,
   input  logic [SRAM_ADDR_W-1:0] i_addr,
   output logic [DATA_W-1:0]      i_rdata,
   // data port
   input  logic                   d_en,
   input  logic [SRAM_ADDR_W-1:0] d_addr,
   input  logic [DATA_W-1:0]      d_wdata,
   input  logic [STRB_W-1:0]      d_wstrb,
   output logic [DATA_W-1:0]      d_rdata
);

   localparam int DEPTH = 2**SRAM_ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   always_ff @(posedge clk) begin
      if (i_en) begin
         i_rdata <= mem[i_addr];
      end
   end

   // read before write, so a write hands back the old word
   always_ff @(posedge clk) begin
      if (d_en) begin
         d_rdata <= mem[d_addr];
         for (int b = 0; b < STRB_W; b++) begin
            if (d_wstrb[b]) begin
               mem[d_addr][8*b +: 8] <= d_wdata[8*b +: 8];
            end
         end
      end
   end

endmodule

// File: rtl/int_mem.sv
`timescale 1ns/10ps

module int_mem import soc_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   // instruction bus
   input  bus_req_t  i_req,
   output bus_resp_t i_resp,
   // data bus
   input  bus_req_t  d_req,
   output bus_resp_t d_resp,
   // boot control
   output logic      boot,
   output logic      cpu_reset
);

   localparam int RST_CNT_W = $clog2(CPU_RESET_CYCLES + 1);

   logic [SRAM_ADDR_W-1:0] i_word;
   logic [DATA_W-1:0]      sram_i_rdata;
   logic [DATA_W-1:0]      sram_d_rdata;
   logic                   boot_sel;
   logic                   boot_wr;
   logic                   i_ready_q;
   logic                   d_ready_q;
   logic                   boot_sel_q;
   logic [RST_CNT_W-1:0]   rst_cnt;

   // while booting, fetches land in the upper half of the sram
   always_comb begin
      i_word = i_req.addr[2 +: SRAM_ADDR_W];
      if (boot) begin
         i_word[BOOT_OFFSET_BIT] = 1'b1;
      end
   end

   assign boot_sel = d_req.addr[B_BIT];
   assign boot_wr  = d_req.valid && boot_sel && (|d_req.wstrb);

   dp_sram sram_inst (
      .clk     (clk),
      .i_en    (i_req.valid),
      .i_addr  (i_word),
      .i_rdata (sram_i_rdata),
      .d_en    (d_req.valid && !boot_sel),
      .d_addr  (d_req.addr[2 +: SRAM_ADDR_W]),
      .d_wdata (d_req.wdata),
      .d_wstrb (d_req.wstrb),
      .d_rdata (sram_d_rdata)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         i_ready_q  <= 1'b0;
         d_ready_q  <= 1'b0;
         boot_sel_q <= 1'b0;
      end else begin
         i_ready_q <= i_req.valid;
         d_ready_q <= d_req.valid;
         if (d_req.valid) begin
            boot_sel_q <= boot_sel;
         end
      end
   end

   // boot register, updated on the edge that launches the response
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         boot <= 1'b1;
      end else if (boot_wr) begin
         boot <= d_req.wdata[0];
      end
   end

   // cpu reset pulse, restarted when boot gets cleared
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rst_cnt <= RST_CNT_W'(CPU_RESET_CYCLES);
      end else if (boot_wr && !d_req.wdata[0]) begin
         rst_cnt <= RST_CNT_W'(CPU_RESET_CYCLES);
      end else if (rst_cnt != '0) begin
         rst_cnt <= rst_cnt - 1'b1;
      end
   end

   assign cpu_reset = (rst_cnt != '0);

   assign i_resp = '{rdata: sram_i_rdata, ready: i_ready_q};
   assign d_resp = '{
      rdata: boot_sel_q ? {{(DATA_W-1){1'b0}}, boot} : sram_d_rdata,
      ready: d_ready_q
   };

   // upper address bits are not decoded and would alias into the sram
   a_i_addr_in_sram: assert property (
      @(posedge clk) disable iff (!arst_n)
         i_req.valid |-> (i_req.addr[ADDR_W-1:SRAM_ADDR_W+2] == '0))
      else $error("int_mem: instruction fetch beyond the sram");

   a_d_addr_in_sram: assert property (
      @(posedge clk) disable iff (!arst_n)
         (d_req.valid && !boot_sel) |-> (d_req.addr[B_BIT-1:SRAM_ADDR_W+2] == '0))
      else $error("int_mem: data access beyond the sram");

endmodule

// File: rtl/timer_regs.sv
`timescale 1ns/10ps

module timer_regs import soc_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  bus_req_t  req,
   output bus_resp_t resp
);

   logic [DATA_W-1:0] count;
   logic [DATA_W-1:0] rdata_q;
   logic              ready_q;
   logic              clear;

   // any write clears the counter
   assign clear = req.valid && (|req.wstrb);

   // free running, wraps at full width
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else if (clear) begin
         count <= '0;
      end else begin
         count <= count + 1'b1;
      end
   end

   // count as seen at the request edge
   always_ff @(posedge clk) begin
      if (req.valid) begin
         rdata_q <= count;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= req.valid;
      end
   end

   assign resp = '{rdata: rdata_q, ready: ready_q};

endmodule

// File: rtl/gpio_regs.sv
`timescale 1ns/10ps

module gpio_regs import soc_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   input  bus_req_t          req,
   output bus_resp_t         resp,
   input  logic [GPIO_W-1:0] gpio_in,
   output logic [GPIO_W-1:0] gpio_out
);

   logic [GPIO_W-1:0] gpio_in_q;
   logic [DATA_W-1:0] rdata_q;
   logic              ready_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         gpio_in_q <= '0;
         gpio_out  <= '0;
         ready_q   <= 1'b0;
      end else begin
         gpio_in_q <= gpio_in;
         ready_q   <= req.valid;
         // output bytes come from the low lanes of the write data
         for (int b = 0; b < GPIO_W/8; b++) begin
            if (req.valid && req.wstrb[b]) begin
               gpio_out[8*b +: 8] <= req.wdata[8*b +: 8];
            end
         end
      end
   end

   // outputs in the high half, sampled inputs in the low half
   always_ff @(posedge clk) begin
      if (req.valid) begin
         rdata_q <= DATA_W'({gpio_out, gpio_in_q});
      end
   end

   assign resp = '{rdata: rdata_q, ready: ready_q};

endmodule

// File: rtl/soc_fabric.sv
`timescale 1ns/10ps

module soc_fabric import soc_pkg::*; (
   input  logic              clk,
   input  logic              arst_n,
   // cpu instruction bus
   input  bus_req_t          ibus_req,
   output bus_resp_t         ibus_resp,
   // cpu data bus
   input  bus_req_t          dbus_req,
   output bus_resp_t         dbus_resp,
   // boot control
   output logic              boot,
   output logic              cpu_reset,
   // gpio pins
   input  logic [GPIO_W-1:0] gpio_in,
   output logic [GPIO_W-1:0] gpio_out
);

   // data bus slaves: 0 internal memory, 1 peripheral bus
   bus_req_t  [1:0] dbus_s_req;
   bus_resp_t [1:0] dbus_s_resp;

   // peripheral slaves: 0 timer, 1 gpio
   bus_req_t  [1:0] pbus_s_req;
   bus_resp_t [1:0] pbus_s_resp;

   bus_split #(
      .N_SLAVES (2),
      .P_SLAVES (P_BIT)
   ) dbus_split (
      .clk    (clk),
      .arst_n (arst_n),
      .m_req  (dbus_req),
      .m_resp (dbus_resp),
      .s_req  (dbus_s_req),
      .s_resp (dbus_s_resp)
   );

   bus_split #(
      .N_SLAVES (2),
      .P_SLAVES (P_BIT-1)
   ) pbus_split (
      .clk    (clk),
      .arst_n (arst_n),
      .m_req  (dbus_s_req[1]),
      .m_resp (dbus_s_resp[1]),
      .s_req  (pbus_s_req),
      .s_resp (pbus_s_resp)
   );

   // instruction bus has a single target
   int_mem int_mem_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .i_req     (ibus_req),
      .i_resp    (ibus_resp),
      .d_req     (dbus_s_req[0]),
      .d_resp    (dbus_s_resp[0]),
      .boot      (boot),
      .cpu_reset (cpu_reset)
   );

   timer_regs timer_inst (
      .clk    (clk),
      .arst_n (arst_n),
      .req    (pbus_s_req[0]),
      .resp   (pbus_s_resp[0])
   );

   gpio_regs gpio_inst (
      .clk      (clk),
      .arst_n   (arst_n),
      .req      (pbus_s_req[1]),
      .resp     (pbus_s_resp[1]),
      .gpio_in  (gpio_in),
      .gpio_out (gpio_out)
   );

endmodule

// File: test/soc_fabric_tb.sv
`timescale 1ns/10ps

module soc_fabric_tb import soc_pkg::*; ();

   localparam int CLK_HALF        = 50;
   localparam int DRIVE_DLY       = 10;
   localparam int RESET_CYCLES    = 10;
   localparam int CYCLES_PER_TEST = 20;

   // operation codes of the test file
   localparam logic [2:0] OP_IR  = 3'd0;
   localparam logic [2:0] OP_DR  = 3'd1;
   localparam logic [2:0] OP_DW  = 3'd2;
   localparam logic [2:0] OP_DI  = 3'd3;
   localparam logic [2:0] OP_GI  = 3'd4;
   localparam logic [2:0] OP_TP  = 3'd5;
   localparam logic [2:0] OP_BAD = 3'd7;

   typedef struct packed {
      logic [2:0]        op;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic [DATA_W-1:0] exp_val;
   } test_line_t;

   logic              clk;
   logic              arst_n;
   bus_req_t          ibus_req;
   bus_resp_t         ibus_resp;
   bus_req_t          dbus_req;
   bus_resp_t         dbus_resp;
   logic              boot;
   logic              cpu_reset;
   logic [GPIO_W-1:0] gpio_in;
   logic [GPIO_W-1:0] gpio_out;

   int         cycle = 0;
   int         timeout_limit = 1000;
   // clock edge that sampled the last request
   int         valid_cycle = 0;
   test_line_t tests[$];

   soc_fabric soc_fabric_inst (
      .clk       (clk),
      .arst_n    (arst_n),
      .ibus_req  (ibus_req),
      .ibus_resp (ibus_resp),
      .dbus_req  (dbus_req),
      .dbus_resp (dbus_resp),
      .boot      (boot),
      .cpu_reset (cpu_reset),
      .gpio_in   (gpio_in),
      .gpio_out  (gpio_out)
   );

   always #CLK_HALF clk = ~clk;

   // edge counter and watchdog
   always @(posedge clk) begin
      cycle <= cycle + 1;
      if (cycle >= timeout_limit) begin
         report_failure($sformatf("timeout after %0d cycles, the tests did not finish", cycle));
      end
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_resp(input bus_resp_t got, input logic [DATA_W-1:0] exp,
                             input string what);
      if (got.rdata !== exp) begin
         report_failure($sformatf("mismatch at %0t: %s returned 0x%08h, expected 0x%08h",
                                  $time, what, got.rdata, exp));
      end
   endtask

   task automatic check_boot(input logic exp_boot, input logic exp_cpu_reset);
      if (boot !== exp_boot || cpu_reset !== exp_cpu_reset) begin
         report_failure($sformatf("mismatch at %0t: boot %b cpu_reset %b, expected %b %b",
                                  $time, boot, cpu_reset, exp_boot, exp_cpu_reset));
      end
   endtask

   task automatic check_gpio(input logic [GPIO_W-1:0] exp);
      if (gpio_out !== exp) begin
         report_failure($sformatf("mismatch at %0t: gpio_out 0x%04h, expected 0x%04h",
                                  $time, gpio_out, exp));
      end
   endtask

   function automatic bus_resp_t resp_of(input logic on_ibus);
      return on_ibus ? ibus_resp : dbus_resp;
   endfunction

   // one request, valid for one cycle, then wait for ready
   task automatic bus_access(input logic on_ibus, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] wstrb,
                             output bus_resp_t resp);
      bus_req_t req;
      int       waited;
      req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
      @(posedge clk);
      #DRIVE_DLY;
      if (resp_of(on_ibus).ready) begin
         report_failure($sformatf("mismatch at %0t: ready high before the request", $time));
      end
      if (on_ibus) begin
         ibus_req = req;
      end else begin
         dbus_req = req;
      end
      valid_cycle = cycle + 1;
      @(posedge clk);
      #DRIVE_DLY;
      ibus_req = '0;
      dbus_req = '0;
      waited   = 1;
      resp     = resp_of(on_ibus);
      while (!resp.ready) begin
         @(posedge clk);
         #DRIVE_DLY;
         waited++;
         resp = resp_of(on_ibus);
      end
      if (waited != 1) begin
         report_failure($sformatf("mismatch at %0t: ready came %0d cycles after valid, not 1",
                                  $time, waited));
      end
   endtask

   // pulse holds for CPU_RESET_CYCLES edges and drops on the last one
   task automatic cpu_reset_pulse(input logic exp_boot);
      check_boot(exp_boot, 1'b1);
      for (int k = 1; k <= CPU_RESET_CYCLES; k++) begin
         @(posedge clk);
         #DRIVE_DLY;
         check_boot(exp_boot, k < CPU_RESET_CYCLES);
      end
   endtask

   task automatic timer_pair(input test_line_t t);
      bus_resp_t first;
      bus_resp_t second;
      int        clear_cycle;
      int        first_cycle;
      bus_access(1'b0, t.addr, t.data, t.strb, first);
      clear_cycle = valid_cycle;
      bus_access(1'b0, t.addr, '0, '0, first);
      first_cycle = valid_cycle;
      // zero after the clear edge, one more on each later edge
      check_resp(first, DATA_W'(first_cycle - clear_cycle - 1), "timer read after clear");
      while (cycle < first_cycle + int'(t.data) - 2) begin
         @(posedge clk);
         #DRIVE_DLY;
      end
      bus_access(1'b0, t.addr, '0, '0, second);
      if (valid_cycle - first_cycle != int'(t.exp_val)) begin
         report_failure($sformatf("timer reads went out %0d cycles apart instead of %0d",
                                  valid_cycle - first_cycle, t.exp_val));
      end
      check_resp(second, DATA_W'(first_cycle - clear_cycle - 1) + t.exp_val,
                 "second timer read");
   endtask

   task automatic run_test(input test_line_t t);
      bus_resp_t resp;
      case (t.op)
         OP_IR: begin
            bus_access(1'b1, t.addr, '0, '0, resp);
            check_resp(resp, t.exp_val, "ibus read");
         end
         OP_DR: begin
            bus_access(1'b0, t.addr, '0, '0, resp);
            check_resp(resp, t.exp_val, "dbus read");
         end
         OP_DI: bus_access(1'b0, t.addr, t.data, t.strb, resp);
         OP_DW: begin
            bus_access(1'b0, t.addr, t.data, t.strb, resp);
            if (t.addr[P_BIT] && t.addr[P_BIT-1]) begin
               check_gpio(t.exp_val[GPIO_W-1:0]);
            end else if (!t.addr[P_BIT] && t.addr[B_BIT]) begin
               // clearing boot restarts the cpu reset pulse
               if (!t.exp_val[0]) begin
                  cpu_reset_pulse(1'b0);
               end else begin
                  check_boot(1'b1, 1'b0);
               end
            end else if (!t.addr[P_BIT]) begin
               check_resp(resp, t.exp_val, "sram write old word");
            end
         end
         OP_GI: begin
            @(posedge clk);
            #DRIVE_DLY;
            gpio_in = t.data[GPIO_W-1:0];
         end
         OP_TP: timer_pair(t);
         default: report_failure("unknown operation code in the test list");
      endcase
   endtask

   function automatic logic [2:0] op_code(input string name);
      if (name == "IR") return OP_IR;
      if (name == "DR") return OP_DR;
      if (name == "DW") return OP_DW;
      if (name == "DI") return OP_DI;
      if (name == "GI") return OP_GI;
      if (name == "TP") return OP_TP;
      return OP_BAD;
   endfunction

   task automatic load_tests();
      int                fd;
      int                fields;
      string             line;
      string             op_name;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic [STRB_W-1:0] strb;
      logic [DATA_W-1:0] exp_val;
      fd = $fopen("test/soc_fabric_tests.txt", "r");
      if (fd == 0) begin
         report_failure("could not open test/soc_fabric_tests.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() > 0 && line[0] != "#") begin
            fields = $sscanf(line, "%s %h %h %h %h", op_name, addr, data, strb, exp_val);
            if (fields == 5) begin
               if (op_code(op_name) == OP_BAD) begin
                  report_failure($sformatf("unknown operation %s in the test file", op_name));
               end
               tests.push_back('{op_code(op_name), addr, data, strb, exp_val});
            end
         end
      end
      $fclose(fd);
   endtask

   initial begin
      clk      = 1'b0;
      arst_n   = 1'b0;
      ibus_req = '0;
      dbus_req = '0;
      gpio_in  = '0;
      load_tests();
      timeout_limit = CYCLES_PER_TEST * tests.size() + RESET_CYCLES + CPU_RESET_CYCLES;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      check_gpio('0);
      if (ibus_resp.ready || dbus_resp.ready) begin
         report_failure($sformatf("mismatch at %0t: ready high while in reset", $time));
      end
      arst_n = 1'b1;
      cpu_reset_pulse(1'b1);
      foreach (tests[i]) begin
         run_test(tests[i]);
      end
      $display("NO ERRORS");
      $finish;
   end

endmodule

// File: test/soc_fabric_tests.txt
# op addr data strb expect, all hex; IR/DR read, DW write, DI write with no check
# GI sets gpio_in, TP clears the timer and reads it twice, data cycles apart
# DW expect: old word for sram, gpio_out for gpio, new boot bit for the boot register
DI 0810 cafef00d f 00000000
DI 0010 0badc0de f 00000000
IR 0010 00000000 0 cafef00d
DR 0810 00000000 0 cafef00d
DR 0010 00000000 0 0badc0de
DI 0020 11223344 f 00000000
DW 0020 aabbccdd 5 11223344
DR 0020 00000000 0 11bb33dd
DW 0020 99887766 8 11bb33dd
DR 0020 00000000 0 99bb33dd
DI 0024 00000000 f 00000000
DW 0024 0000ab00 2 00000000
DR 0024 00000000 0 0000ab00
DR 2000 00000000 0 00000001
GI 0000 00001234 0 00000000
DW 6000 0000a55a 3 0000a55a
DW 6000 00003c00 2 00003c5a
DR 6000 00000000 0 3c5a1234
GI 0000 0000beef 0 00000000
DR 6000 00000000 0 3c5abeef
TP 4000 00000005 f 00000005
TP 4000 0000000c 1 0000000c
DW 2000 00000000 1 00000000
DR 2000 00000000 0 00000000
IR 0010 00000000 0 0badc0de
IR 0810 00000000 0 cafef00d

// File: soc_fabric.f
rtl/soc_pkg.sv
rtl/bus_split.sv
rtl/dp_sram.sv
rtl/int_mem.sv
rtl/timer_regs.sv
rtl/gpio_regs.sv
rtl/soc_fabric.sv
test/soc_fabric_tb.sv

// File: Bender.yml
package:
  name: soc_fabric

sources:
  - files:
      - rtl/soc_pkg.sv
      - rtl/bus_split.sv
      - rtl/dp_sram.sv
      - rtl/int_mem.sv
      - rtl/timer_regs.sv
      - rtl/gpio_regs.sv
      - rtl/soc_fabric.sv
  - target: test
    files:
      - test/soc_fabric_tb.sv
